//--- verilog.f
+incdir+src
src/proc_pkg.sv
src/mem_port_ctrl.sv
src/fetch_stage.sv
src/decode_stage.sv
src/hazard_unit.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/proc_top.sv
testbench/proc_sva.sv
testbench/proc_tb.sv

//--- testbench/proc_tb.sv
//////////////////////////////////////////////////////////////////////
// Core testbench: random programs, memory with random latency,
// sequential ISA model and store-by-store comparison
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "proc_cfg.svh"

module proc_tb;

  localparam int num_tests  = 4;
  localparam int prog_words = 64;                 // 15 LLB, body, 16 dump stores, HLT
  localparam int body_len   = 32;
  localparam int max_cycles = prog_words * 8 * num_tests;

  logic               clk, rst, mem_data_valid, mem_en, mem_wr, hlt;
  logic [`DATA_W-1:0] mem_data_in, mem_addr, mem_data_out, pc;
  logic [`DATA_W-1:0] mem [0:65535];              // What the DUT sees
  logic [`DATA_W-1:0] ref_mem [0:65535];          // Model copy
  logic [`DATA_W-1:0] exp_addr [$], exp_data [$], got_addr [$], got_data [$];
  logic [`DATA_W-1:0] hlt_addr;
  logic [31:0]        lcg_state = 32'h39a8;
  int                 cycles = 0, late_en = 0, errors = 0, tests_failed = 0;
  string              names [num_tests] = '{"alu_ops", "dependent", "load_use", "mixed_mem"};

  proc_top u_dut (.*);
  bind proc_top proc_sva u_sva (.*);

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    mem_data_valid = 1'b0;
    mem_data_in = '0;
  end

  always #20 clk = ~clk;                           // 40 ns period

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic logic [15:0] enc(input logic [3:0] op, a, b, c);
    return {op, a, b, c};
  endfunction

  function automatic logic [3:0] alu_opcode(input logic [15:0] k);
    return (k % 3 == 0) ? `OP_ADD : (k % 3 == 1) ? `OP_SUB : `OP_XOR;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Program generation and reference model
  //////////////////////////////////////////////////////////////////////
  task automatic build_program(input int kind);
    int         n;
    logic [3:0] rd, ra, rb, prev;
    logic [2:0] sel;
    for (int a = 0; a < 65536; a++) mem[a] = lcg_next();  // Data half starts random
    n = 0;
    for (int r = 1; r < 16; r++) begin
      mem[n++] = enc(`OP_LLB, 4'(r), 4'(lcg_next()), 4'(lcg_next()));
    end
    prev = 4'd1;
    for (int i = 0; i < body_len; i++) begin
      ra  = 4'(lcg_next());
      rb  = 4'(lcg_next());                       // Also the LW/SW offset
      sel = 3'(lcg_next() % 6);
      rd  = (kind == 0 || kind == 3) ? 4'(lcg_next()) : 4'(1 + lcg_next() % 15);
      case (kind)
        0: mem[n] = (sel < 4) ? enc(alu_opcode(sel), rd, ra, rb) : enc(`OP_LLB, rd, ra, rb);
        1: mem[n] = sel[0] ? enc(alu_opcode(sel), rd, prev, rb)
                           : enc(alu_opcode(sel), rd, ra, prev);
        2: case (i % 3)
             0: mem[n] = enc(`OP_LW, rd, ra, rb);    // Result used right away
             1: mem[n] = sel[0] ? enc(`OP_ADD, rd, prev, rb) : enc(`OP_SUB, rd, ra, prev);
             default: mem[n] = enc(`OP_SW, prev, ra, rb);
           endcase
        default: case (sel)
                   3: mem[n] = enc(`OP_LLB, rd, ra, rb);
                   4: mem[n] = enc(`OP_LW, rd, ra, rb);
                   5: mem[n] = enc(`OP_SW, rd, ra, rb);
                   default: mem[n] = enc(alu_opcode(sel), rd, ra, rb);
                 endcase
      endcase
      if (!(kind == 2 && i % 3 == 2)) prev = rd;
      n++;
    end
    for (int r = 0; r < 16; r++) mem[n++] = enc(`OP_SW, 4'(r), 4'h0, 4'(r));  // Dump
    mem[n] = enc(`OP_HLT, 4'h0, 4'h0, 4'h0);
  endtask

  task automatic run_model();
    logic [15:0] regs [16];
    logic [15:0] ir, addr, rpc;
    for (int r = 0; r < 16; r++) regs[r] = '0;
    exp_addr.delete();
    exp_data.delete();
    rpc = '0;
    ir  = ref_mem[rpc];
    while (ir[15:12] != `OP_HLT) begin
      addr = (regs[ir[7:4]] + ir[3:0]) | 16'h8000;   // Data lives in the upper half
      case (ir[15:12])
        `OP_ADD: regs[ir[11:8]] = regs[ir[7:4]] + regs[ir[3:0]];
        `OP_SUB: regs[ir[11:8]] = regs[ir[7:4]] - regs[ir[3:0]];
        `OP_XOR: regs[ir[11:8]] = regs[ir[7:4]] ^ regs[ir[3:0]];
        `OP_LLB: regs[ir[11:8]] = {8'h00, ir[7:0]};
        `OP_LW:  regs[ir[11:8]] = ref_mem[addr];
        `OP_SW: begin
          ref_mem[addr] = regs[ir[11:8]];
          exp_addr.push_back(addr);
          exp_data.push_back(regs[ir[11:8]]);
        end
        default: ;
      endcase
      regs[0] = '0;                               // r0 is hardwired
      rpc++;
      ir = ref_mem[rpc];
    end
    hlt_addr = rpc;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory model, timeout and checks
  //////////////////////////////////////////////////////////////////////
  always begin : mem_model
    logic [15:0] a, d;
    logic        w;
    int          lat;
    @(posedge clk);
    if (!rst && mem_en) begin
      a = mem_addr;
      w = mem_wr;
      d = mem_data_out;
      lat = 1 + lcg_next() % 4;                   // 1 to 4 cycles
      repeat (lat - 1) @(posedge clk);
      #2;
      if (w) begin
        mem[a] = d;
        got_addr.push_back(a);
        got_data.push_back(d);
      end
      mem_data_in    = mem[a];
      mem_data_valid = 1'b1;
      @(posedge clk);
      #2 mem_data_valid = 1'b0;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (!rst && hlt && mem_en) late_en++;         // Nothing may follow a halt
    if (cycles > max_cycles) begin
      $display("Timeout: the core did not halt within %0d cycles", max_cycles);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic compare_word(input string name, input logic [15:0] got, exp);
    assert (got === exp) else begin
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic run_test(input int kind);
    int errs_before, sva_before, n;
    errs_before = errors;
    sva_before  = u_dut.u_sva.fail_count;
    build_program(kind);
    ref_mem = mem;
    run_model();
    got_addr.delete();
    got_data.delete();
    late_en = 0;
    @(posedge clk);
    #2 rst = 1'b1;
    repeat (10) @(posedge clk);
    #2 rst = 1'b0;
    do begin
      @(posedge clk);
    end while (!hlt);
    compare_word("store count", 16'(got_addr.size()), 16'(exp_addr.size()));
    n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
    for (int i = 0; i < n; i++) begin
      compare_word($sformatf("store_addr[%0d]", i), got_addr[i], exp_addr[i]);
      compare_word($sformatf("store_data[%0d]", i), got_data[i], exp_data[i]);
      assert (got_addr[i][15]) else begin
        $display("Store %0d went to %h, below the data half of memory", i, got_addr[i]);
        errors++;
      end
    end
    compare_word("pc", pc, hlt_addr);             // Parked on the HLT word
    repeat (10) @(posedge clk);
    assert (late_en == 0) else begin
      $display("The core issued %0d memory accesses after hlt rose", late_en);
      errors++;
    end
    errors += u_dut.u_sva.fail_count - sva_before;  // Bound port and halt assertions
    if (errors == errs_before) begin
      $display("Test %0d %s: ok, %0d stores", kind + 1, names[kind], n);
    end else begin
      $display("Test %0d %s: FAILED with %0d errors", kind + 1, names[kind], errors - errs_before);
      tests_failed++;
    end
  endtask

  initial begin
    for (int k = 0; k < num_tests; k++) run_test(k);
    $display("Tests run %0d, passed %0d, failed %0d, check errors %0d",
             num_tests, num_tests - tests_failed, tests_failed, errors);
    if (errors == 0) $display("Regression passed");
    else $display("Regression failed");
    $finish;
  end

endmodule

//--- testbench/proc_sva.sv
//////////////////////////////////////////////////////////////////////
// Memory port and halt assertions, bound into the core top level
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module proc_sva (
  input logic clk,
  input logic rst,
  input logic mem_en,
  input logic mem_wr,
  input logic mem_data_valid,
  input logic hlt
);

  logic pending;                                  // Access issued, not yet answered
  int   fail_count = 0;                           // Failed assertions so far

  always_ff @(posedge clk) begin
    if (rst) pending <= 1'b0;
    else if (mem_en) pending <= 1'b1;
    else if (mem_data_valid) pending <= 1'b0;
  end

  en_pulse: assert property (@(posedge clk) disable iff (rst) mem_en |=> !mem_en)
    else begin
      $error("mem_en held longer than one cycle");
      fail_count++;
    end
  en_in_flight: assert property (@(posedge clk) disable iff (rst) pending |-> !mem_en)
    else begin
      $error("mem_en issued before mem_data_valid of the previous access");
      fail_count++;
    end
  hlt_sticky: assert property (@(posedge clk) disable iff (rst) hlt |=> hlt)
    else begin
      $error("hlt fell outside reset");
      fail_count++;
    end
  reset_values: assert property (@(posedge clk) $fell(rst) |-> !mem_en && !mem_wr && !hlt)
    else begin
      $error("mem_en, mem_wr or hlt high after reset");
      fail_count++;
    end

endmodule

//--- src/proc_top.sv
//////////////////////////////////////////////////////////////////////
// Five-stage 16-bit core with a single shared memory port
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "proc_cfg.svh"

module proc_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              mem_data_valid,  // One pulse per access
  input  logic [`DATA_W-1:0] mem_data_in,
  output logic              mem_en,
  output logic [`DATA_W-1:0] mem_addr,
  output logic              mem_wr,
  output logic [`DATA_W-1:0] mem_data_out,
  output logic              hlt,
  output logic [`DATA_W-1:0] pc
);

  logic                fetch_req, fetch_done;
  logic [`DATA_W-1:0]  fetch_addr, fetch_word;
  logic                data_req, data_wr, data_done;
  logic [`DATA_W-1:0]  data_addr, data_wdata, data_rdata;
  logic                freeze, load_use;
  logic [1:0]          fwd_a, fwd_b;        // Bit 1 EX/MEM, bit 0 MEM/WB
  logic                if_id_valid;
  proc_pkg::instr_u    if_id_instr;
  logic [`REG_W-1:0]   id_rs, id_rt;
  proc_pkg::ctrl_t     id_ex_ctrl, ex_mem_ctrl, mem_wb_ctrl;
  logic [`DATA_W-1:0]  id_ex_a, id_ex_b, id_ex_imm;
  logic [`REG_W-1:0]   id_ex_rd, id_ex_rs, id_ex_rt, ex_mem_rd, mem_wb_rd;
  logic [`DATA_W-1:0]  ex_mem_result, ex_mem_store;
  logic                wb_en;
  logic [`REG_W-1:0]   wb_rd;
  logic [`DATA_W-1:0]  wb_data;

  mem_port_ctrl u_port (.*);

  fetch_stage u_fetch (.*);

  decode_stage u_decode (.*);

  hazard_unit u_hazard (.*);

  execute_stage u_execute (.*);

  mem_wb_stage u_mem_wb (.*);

endmodule

//--- src/mem_wb_stage.sv
//////////////////////////////////////////////////////////////////////
// Memory access request, MEM/WB register, write-back and halt
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "proc_cfg.svh"

module mem_wb_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               freeze,
  input  proc_pkg::ctrl_t    ex_mem_ctrl,
  input  logic [`DATA_W-1:0] ex_mem_result,
  input  logic [`DATA_W-1:0] ex_mem_store,
  input  logic [`REG_W-1:0]  ex_mem_rd,
  input  logic               data_done,
  input  logic [`DATA_W-1:0] data_rdata,
  output logic               data_req,
  output logic               data_wr,
  output logic [`DATA_W-1:0] data_addr,
  output logic [`DATA_W-1:0] data_wdata,
  output proc_pkg::ctrl_t    mem_wb_ctrl,
  output logic [`REG_W-1:0]  mem_wb_rd,
  output logic               wb_en,
  output logic [`REG_W-1:0]  wb_rd,
  output logic [`DATA_W-1:0] wb_data,
  output logic               hlt
);

  logic [`DATA_W-1:0] mem_wb_data;

  // Held steady by the freeze until the port answers
  assign data_req   = ex_mem_ctrl.mem_en;
  assign data_wr    = ex_mem_ctrl.mem_write;
  assign data_addr  = ex_mem_result;
  assign data_wdata = ex_mem_store;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb_ctrl <= '0;
      hlt         <= 1'b0;
    end else begin
      if (!freeze) mem_wb_ctrl <= ex_mem_ctrl;
      if (mem_wb_ctrl.is_hlt) hlt <= 1'b1;  // Sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      mem_wb_rd   <= ex_mem_rd;
      mem_wb_data <= (ex_mem_ctrl.mem_to_reg && data_done) ? data_rdata : ex_mem_result;
    end
  end

  assign wb_en   = mem_wb_ctrl.reg_write;
  assign wb_rd   = mem_wb_rd;
  assign wb_data = mem_wb_data;

endmodule

//--- src/execute_stage.sv
//////////////////////////////////////////////////////////////////////
// Execute: operand forwarding, ALU, address generation and EX/MEM
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "proc_cfg.svh"

module execute_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               freeze,
  input  proc_pkg::ctrl_t    id_ex_ctrl,
  input  logic [`DATA_W-1:0] id_ex_a,
  input  logic [`DATA_W-1:0] id_ex_b,
  input  logic [`DATA_W-1:0] id_ex_imm,
  input  logic [`REG_W-1:0]  id_ex_rd,
  input  logic [1:0]         fwd_a,
  input  logic [1:0]         fwd_b,
  input  logic [`DATA_W-1:0] wb_data,
  output proc_pkg::ctrl_t    ex_mem_ctrl,
  output logic [`DATA_W-1:0] ex_mem_result,
  output logic [`DATA_W-1:0] ex_mem_store,
  output logic [`REG_W-1:0]  ex_mem_rd
);

  logic [`DATA_W-1:0] op_a, reg_b, op_b, alu_out;

  assign op_a  = fwd_a[1] ? ex_mem_result : fwd_a[0] ? wb_data : id_ex_a;
  assign reg_b = fwd_b[1] ? ex_mem_result : fwd_b[0] ? wb_data : id_ex_b;  // Also SW data
  assign op_b  = id_ex_ctrl.alu_sel ? id_ex_imm : reg_b;

  always_comb begin
    case (id_ex_ctrl.alu_op)
      proc_pkg::alu_sub: alu_out = op_a - op_b;
      proc_pkg::alu_xor: alu_out = op_a ^ op_b;
      proc_pkg::alu_pass_b: alu_out = op_b;
      default: alu_out = op_a + op_b;
    endcase
    if (id_ex_ctrl.mem_en) alu_out[`DATA_W-1] = 1'b1;  // Data in upper half
  end

  always_ff @(posedge clk) begin
    if (rst) ex_mem_ctrl <= '0;
    else if (!freeze) ex_mem_ctrl <= id_ex_ctrl;
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      ex_mem_result <= alu_out;
      ex_mem_store  <= reg_b;
      ex_mem_rd     <= id_ex_rd;
    end
  end

endmodule

//--- src/hazard_unit.sv
//////////////////////////////////////////////////////////////////////
// Hazards: forwarding selects, load-use stall, data access freeze
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "proc_cfg.svh"

module hazard_unit (
  input  logic [`REG_W-1:0] id_rs,
  input  logic [`REG_W-1:0] id_rt,
  input  proc_pkg::ctrl_t   id_ex_ctrl,
  input  logic [`REG_W-1:0] id_ex_rd,
  input  logic [`REG_W-1:0] id_ex_rs,
  input  logic [`REG_W-1:0] id_ex_rt,
  input  proc_pkg::ctrl_t   ex_mem_ctrl,
  input  logic [`REG_W-1:0] ex_mem_rd,
  input  proc_pkg::ctrl_t   mem_wb_ctrl,
  input  logic [`REG_W-1:0] mem_wb_rd,
  input  logic              data_req,
  input  logic              data_done,
  output logic              load_use,
  output logic              freeze,
  output logic [1:0]        fwd_a,  // Bit 1 EX/MEM wins over bit 0 MEM/WB
  output logic [1:0]        fwd_b
);

  logic ex_mem_wr, mem_wb_wr;

  assign ex_mem_wr = ex_mem_ctrl.reg_write & (ex_mem_rd != '0);  // r0 never forwards
  assign mem_wb_wr = mem_wb_ctrl.reg_write & (mem_wb_rd != '0);

  assign fwd_a = {ex_mem_wr & (ex_mem_rd == id_ex_rs), mem_wb_wr & (mem_wb_rd == id_ex_rs)};
  assign fwd_b = {ex_mem_wr & (ex_mem_rd == id_ex_rt), mem_wb_wr & (mem_wb_rd == id_ex_rt)};

  // LW in execute whose result decode needs next
  assign load_use = id_ex_ctrl.mem_to_reg & (id_ex_rd != '0) &
                    ((id_ex_rd == id_rs) | (id_ex_rd == id_rt));

  assign freeze = data_req & ~data_done;  // Whole pipe waits on the data port

endmodule

//--- src/decode_stage.sv
//////////////////////////////////////////////////////////////////////
// Decode: control generation, register file with bypass, ID/EX
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "proc_cfg.svh"

module decode_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               freeze,
  input  logic               load_use,
  input  logic               if_id_valid,
  input  proc_pkg::instr_u   if_id_instr,
  input  logic               wb_en,
  input  logic [`REG_W-1:0]  wb_rd,
  input  logic [`DATA_W-1:0] wb_data,
  output logic [`REG_W-1:0]  id_rs,
  output logic [`REG_W-1:0]  id_rt,
  output proc_pkg::ctrl_t    id_ex_ctrl,
  output logic [`DATA_W-1:0] id_ex_a,
  output logic [`DATA_W-1:0] id_ex_b,
  output logic [`DATA_W-1:0] id_ex_imm,
  output logic [`REG_W-1:0]  id_ex_rd,
  output logic [`REG_W-1:0]  id_ex_rs,
  output logic [`REG_W-1:0]  id_ex_rt
);

  logic [`DATA_W-1:0] regs [`NUM_REGS];
  logic [3:0]         opcode;
  proc_pkg::ctrl_t    ctrl;
  logic [`DATA_W-1:0] imm, rd_a, rd_b;

  //////////////////////////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////////////////////////
  assign opcode = if_id_instr.reg_f.opcode;

  always_comb begin
    ctrl   = '0;
    imm    = {12'h000, if_id_instr.imm_f.off4};     // LW and SW offset
    id_rs  = if_id_instr.reg_f.rs;
    id_rt  = if_id_instr.reg_f.rt;
    case (opcode)
      `OP_ADD: ctrl.reg_write = 1'b1;
      `OP_SUB: {ctrl.reg_write, ctrl.alu_op} = {1'b1, proc_pkg::alu_sub};
      `OP_XOR: {ctrl.reg_write, ctrl.alu_op} = {1'b1, proc_pkg::alu_xor};
      `OP_LW: begin
        {ctrl.reg_write, ctrl.mem_en, ctrl.mem_to_reg, ctrl.alu_sel} = 4'b1111;
        id_rt = '0;                                   // No second source
      end
      `OP_SW: begin
        {ctrl.mem_en, ctrl.mem_write, ctrl.alu_sel} = 3'b111;
        id_rt = if_id_instr.imm_f.rd;                 // Store data register
      end
      `OP_LLB: begin
        {ctrl.reg_write, ctrl.alu_sel} = 2'b11;
        ctrl.alu_op = proc_pkg::alu_pass_b;
        imm   = {8'h00, if_id_instr.imm_f.rs, if_id_instr.imm_f.off4};
        id_rs = '0;
        id_rt = '0;
      end
      `OP_HLT: begin
        ctrl.is_hlt = 1'b1;
        id_rs = '0;
        id_rt = '0;
      end
      default: ctrl = '0;                             // Unused opcode is a no-op
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Register file, write-through bypass, r0 reads zero
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wb_en && wb_rd != '0) regs[wb_rd] <= wb_data;
  end

  assign rd_a = (id_rs == '0) ? '0 : (wb_en && wb_rd == id_rs) ? wb_data : regs[id_rs];
  assign rd_b = (id_rt == '0) ? '0 : (wb_en && wb_rd == id_rt) ? wb_data : regs[id_rt];

  // ID/EX register, bubble on load-use or empty IF/ID
  always_ff @(posedge clk) begin
    if (rst) id_ex_ctrl <= '0;
    else if (!freeze) id_ex_ctrl <= (load_use || !if_id_valid) ? '0 : ctrl;
  end

  always_ff @(posedge clk) begin
    if (!freeze) begin
      id_ex_a   <= rd_a;
      id_ex_b   <= rd_b;
      id_ex_imm <= imm;
      id_ex_rd  <= if_id_instr.imm_f.rd;
      id_ex_rs  <= id_rs;
      id_ex_rt  <= id_rt;
    end
  end

endmodule

//--- src/fetch_stage.sv
//////////////////////////////////////////////////////////////////////
// Fetch: pc, fetch request, one-word holding buffer and IF/ID
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "proc_cfg.svh"

module fetch_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               freeze,
  input  logic               load_use,
  input  logic               fetch_done,
  input  logic [`DATA_W-1:0] fetch_word,
  output logic               fetch_req,
  output logic [`DATA_W-1:0] fetch_addr,
  output logic [`DATA_W-1:0] pc,
  output logic               if_id_valid,
  output proc_pkg::instr_u   if_id_instr
);

  logic               buf_valid;            // Fetched word waiting for IF/ID
  logic [`DATA_W-1:0] buf_word;
  logic               hlt_seen;             // HLT passed into IF/ID
  logic               advance;              // IF/ID may take a word
  logic               avail;
  logic [`DATA_W-1:0] next_word;
  logic               next_is_hlt;

  assign advance     = ~freeze & ~load_use;
  assign avail       = buf_valid | fetch_done;
  assign next_word   = buf_valid ? buf_word : fetch_word;
  assign next_is_hlt = next_word[15:12] == `OP_HLT;

  assign fetch_req  = ~hlt_seen & ~buf_valid;  // One word in hand at most
  assign fetch_addr = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= `RESET_PC;
      hlt_seen    <= 1'b0;
      buf_valid   <= 1'b0;
      if_id_valid <= 1'b0;
    end else begin
      if (advance) begin
        if_id_valid <= avail;               // Bubble when nothing fetched
        buf_valid   <= 1'b0;
        if (avail && next_is_hlt) hlt_seen <= 1'b1;
        else if (avail)           pc <= pc + 1'b1;  // Word addressed
      end else if (fetch_done) begin
        buf_valid <= 1'b1;                  // Stalled, park the word
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_done && !advance) buf_word <= fetch_word;
    if (advance) if_id_instr <= next_word;
  end

endmodule

//--- src/mem_port_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Memory port arbiter, data wins when idle, fetch in flight finishes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "proc_cfg.svh"

module mem_port_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               fetch_req,
  input  logic [`DATA_W-1:0] fetch_addr,
  input  logic               data_req,
  input  logic               data_wr,
  input  logic [`DATA_W-1:0] data_addr,
  input  logic [`DATA_W-1:0] data_wdata,
  input  logic               mem_data_valid,
  input  logic [`DATA_W-1:0] mem_data_in,
  output logic               mem_en,
  output logic [`DATA_W-1:0] mem_addr,
  output logic               mem_wr,
  output logic [`DATA_W-1:0] mem_data_out,
  output logic               fetch_done,
  output logic [`DATA_W-1:0] fetch_word,
  output logic               data_done,
  output logic [`DATA_W-1:0] data_rdata
);

  typedef enum logic [1:0] {st_idle, st_fetch, st_data} port_state_e;
  port_state_e state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_idle;
      mem_en <= 1'b0;
      mem_wr <= 1'b0;
    end else begin
      mem_en <= 1'b0;                       // Single-cycle strobe
      case (state)
        st_idle: begin
          mem_wr <= data_req & data_wr;     // Fetches are always reads
          if (data_req) begin
            state  <= st_data;
            mem_en <= 1'b1;
          end else if (fetch_req) begin
            state  <= st_fetch;
            mem_en <= 1'b1;
          end
        end
        st_fetch, st_data: if (mem_data_valid) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // Address and write data of the winner, captured at issue
  always_ff @(posedge clk) begin
    if (state == st_idle) begin
      mem_addr     <= data_req ? data_addr : fetch_addr;
      mem_data_out <= data_wdata;
    end
  end

  assign fetch_done = (state == st_fetch) & mem_data_valid;  // Word back to fetch
  assign data_done  = (state == st_data) & mem_data_valid;   // Also acks stores
  assign fetch_word = mem_data_in;
  assign data_rdata = mem_data_in;

endmodule

//--- src/proc_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types: instruction word views, stage control, ALU ops
//////////////////////////////////////////////////////////////////////
`include "proc_cfg.svh"

package proc_pkg;

  typedef enum logic [1:0] {
    alu_add,                    // A + B, also address generation
    alu_sub,                    // A - B
    alu_xor,                    // A ^ B
    alu_pass_b                  // B unchanged, used by LLB
  } alu_op_e;

  typedef struct packed {
    logic [3:0]        opcode;
    logic [`REG_W-1:0] rd;
    logic [`REG_W-1:0] rs;
    logic [`REG_W-1:0] rt;
  } reg_fmt_t;

  typedef struct packed {
    logic [3:0]        opcode;
    logic [`REG_W-1:0] rd;      // Store data register for SW
    logic [`REG_W-1:0] rs;      // Base register, LLB immediate high nibble
    logic [3:0]        off4;    // Offset, LLB immediate low nibble
  } imm_fmt_t;

  typedef union packed {
    reg_fmt_t reg_f;
    imm_fmt_t imm_f;
  } instr_u;

  typedef struct packed {
    logic    reg_write;         // Writes rd in write-back
    logic    mem_en;            // LW or SW
    logic    mem_write;         // SW
    logic    mem_to_reg;        // Write back the loaded word
    logic    is_hlt;
    logic    alu_sel;           // Immediate replaces operand B
    alu_op_e alu_op;
  } ctrl_t;

endpackage

//--- src/proc_cfg.svh
//////////////////////////////////////////////////////////////////////
// Processor configuration: widths, opcode values and reset pc
//////////////////////////////////////////////////////////////////////
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

`define DATA_W    16        // Data and address width
`define NUM_REGS  16        // Register file depth
`define REG_W     4         // Register index width

// Opcodes, upper nibble of the instruction word
`define OP_ADD    4'h0
`define OP_SUB    4'h1
`define OP_XOR    4'h2
`define OP_LW     4'h8
`define OP_SW     4'h9
`define OP_LLB    4'ha
`define OP_HLT    4'hf

`define RESET_PC  16'h0000  // First instruction address

`endif
